//--- dv/sram_soc_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module sram_soc_asserts (
    input logic clk_i,
    input logic rst_n,
    input logic host_req_i,
    input logic host_gnt_i,
    input logic host_rvalid_i,
    input logic core_req_i,
    input logic core_gnt_i,
    input logic core_rvalid_i
);

    int fail_count = 0;

    // Fixed priority never grants both sides
    grant_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n)
        !(host_gnt_i && core_gnt_i))
        else begin
            $error("host and core granted in the same cycle");
            fail_count++;
        end

    // Responses trail their own grant by one cycle
    host_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n)
        host_rvalid_i |-> $past(host_req_i && host_gnt_i))
        else begin
            $error("host rvalid without a host grant one cycle earlier");
            fail_count++;
        end

    core_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n)
        core_rvalid_i |-> $past(core_req_i && core_gnt_i))
        else begin
            $error("core rvalid without a core grant one cycle earlier");
            fail_count++;
        end

    core_blocked_by_host: assert property (@(posedge clk_i) disable iff (!rst_n)
        host_req_i |-> !core_gnt_i)
        else begin
            $error("core granted while the host requests");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- dv/sram_soc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sram_soc_checker (
    input  logic                   clk_i,
    input  logic                   rst_n,
    input  int unsigned            depth_i,
    input  soc_bus_pkg::host_key_t host_key_i,
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_we_i,
    input  soc_bus_pkg::be_t       wbs_sel_i,
    input  soc_bus_pkg::addr_t     wbs_adr_i,
    input  soc_bus_pkg::data_t     wbs_dat_i,
    input  logic                   wbs_ack_i,
    input  soc_bus_pkg::data_t     wbs_rdata_i,
    input  logic                   core_req_i,
    input  logic                   core_gnt_i,
    input  soc_bus_pkg::addr_t     core_addr_i,
    input  logic                   core_we_i,
    input  soc_bus_pkg::be_t       core_be_i,
    input  soc_bus_pkg::data_t     core_wdata_i,
    input  logic                   core_rvalid_i,
    input  soc_bus_pkg::data_t     core_rdata_i,
    input  logic                   mem_err_i,
    output int                     error_count_o
);
    import soc_bus_pkg::*;

    data_t ref_mem [int unsigned];
    logic  host_we_q [$];
    data_t host_exp_q [$];
    logic  core_we_q [$];
    data_t core_exp_q [$];
    logic  host_busy;
    logic  err_model;
    logic  core_rsp_due;
    int    error_count = 0;

    assign error_count_o = error_count;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Host window lands on the SRAM by a top nibble of 8
    function automatic addr_t remap_host(input addr_t addr);
        if (addr >= REMAP_LO && addr < REMAP_HI) begin
            return {4'h8, addr[27:0]};
        end
        return addr;
    endfunction

    function automatic bit in_sram(input addr_t addr);
        return (addr >= SRAM_BASE) && ((addr - SRAM_BASE) < 4 * depth_i);
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t wdata, input be_t be);
        data_t word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return word;
    endfunction

    function automatic data_t expected_read(input addr_t addr, input bit from_host);
        addr_t       target;
        int unsigned idx;
        target = from_host ? remap_host(addr) : addr;
        idx    = (target - SRAM_BASE) >> 2;
        if (!in_sram(target)) begin
            return '0;
        end
        return ref_mem.exists(idx) ? ref_mem[idx] : 'x;
    endfunction

    task automatic record_access(input addr_t addr, input bit from_host, input logic we,
                                 input be_t be, input data_t wdata);
        addr_t target;
        target = from_host ? remap_host(addr) : addr;
        if (!in_sram(target)) begin
            err_model <= 1'b1;
        end else if (we) begin
            ref_mem[(target - SRAM_BASE) >> 2] = merge_bytes(expected_read(addr, from_host),
                                                             wdata, be);
        end
        if (from_host) begin
            host_we_q.push_back(we);
            host_exp_q.push_back(expected_read(addr, from_host));
        end else begin
            core_we_q.push_back(we);
            core_exp_q.push_back(expected_read(addr, from_host));
        end
    endtask

    task automatic log_mismatch(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        error_count++;
    endtask

    ////////////////////////////////////////////////////////////
    // Accepted requests
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!rst_n) begin
            host_busy = 1'b0;
            host_we_q.delete();
            host_exp_q.delete();
            core_we_q.delete();
            core_exp_q.delete();
            err_model    <= 1'b0;
            core_rsp_due <= 1'b0;
        end else begin
            // Bridge takes a strobe only when idle and unlocked
            if (host_busy) begin
                if (wbs_ack_i) begin
                    host_busy = 1'b0;
                end
            end else if (wbs_cyc_i && wbs_stb_i && host_key_i == HOST_UNLOCK_KEY) begin
                host_busy = 1'b1;
                record_access(wbs_adr_i, 1'b1, wbs_we_i, wbs_sel_i, wbs_dat_i);
            end
            if (core_req_i && core_gnt_i) begin
                record_access(core_addr_i, 1'b0, core_we_i, core_be_i, core_wdata_i);
            end
            core_rsp_due <= core_req_i && core_gnt_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Response comparison
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        logic  we;
        data_t exp;
        if (rst_n) begin
            if (core_rvalid_i !== core_rsp_due) begin
                log_mismatch($sformatf("core rvalid %b, expected %b", core_rvalid_i, core_rsp_due));
            end
            if (core_rvalid_i === 1'b1 && core_we_q.size() == 0) begin
                $display("Core response at %0t ns arrived with no request in flight", $time);
                error_count++;
            end else if (core_rvalid_i === 1'b1) begin
                we  = core_we_q.pop_front();
                exp = core_exp_q.pop_front();
                if (!we && core_rdata_i !== exp) begin
                    log_mismatch($sformatf("core read %h, expected %h", core_rdata_i, exp));
                end
            end
            if (wbs_ack_i === 1'b1 && host_we_q.size() == 0) begin
                $display("Host ack at %0t ns arrived with no cycle in flight", $time);
                error_count++;
            end else if (wbs_ack_i === 1'b1) begin
                we  = host_we_q.pop_front();
                exp = host_exp_q.pop_front();
                if (!we && wbs_rdata_i !== exp) begin
                    log_mismatch($sformatf("host read %h, expected %h", wbs_rdata_i, exp));
                end
            end
            if (mem_err_i !== err_model) begin
                log_mismatch($sformatf("mem_err %b, expected %b", mem_err_i, err_model));
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_sram_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_soc;
    import soc_bus_pkg::*;

    localparam int TEST_WORDS  = 32;
    localparam int ACK_LIMIT   = 20;
    // Roughly 200 transactions of at most 4 cycles, with a wide margin
    localparam int MAX_TRANS      = 200;
    localparam int TRANS_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = MAX_TRANS * TRANS_CYCLES * 6 + 200;

    logic      clk_i;
    logic      rst_n;
    logic      wbs_cyc;
    logic      wbs_stb;
    logic      wbs_we;
    be_t       wbs_sel;
    addr_t     wbs_adr;
    data_t     wbs_dat;
    logic      wbs_ack;
    data_t     wbs_rdata;
    host_key_t host_key;
    logic      core_req;
    logic      core_gnt;
    addr_t     core_addr;
    logic      core_we;
    be_t       core_be;
    data_t     core_wdata;
    logic      core_rvalid;
    data_t     core_rdata;
    logic      mem_err;

    int unsigned sram_words;
    int          checker_errors;
    int          tb_errors = 0;
    int          errors_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count;
    integer      seed;

    sram_soc_top u_sram_soc_top (
        .clk_i, .rst_n,
        .wbs_cyc_i (wbs_cyc), .wbs_stb_i (wbs_stb), .wbs_we_i (wbs_we),
        .wbs_sel_i (wbs_sel), .wbs_adr_i (wbs_adr), .wbs_dat_i (wbs_dat),
        .wbs_ack_o (wbs_ack), .wbs_dat_o (wbs_rdata),
        .host_key_i (host_key),
        .core_req_i (core_req), .core_gnt_o (core_gnt), .core_addr_i (core_addr),
        .core_we_i (core_we), .core_be_i (core_be), .core_wdata_i (core_wdata),
        .core_rvalid_o (core_rvalid), .core_rdata_o (core_rdata),
        .mem_err_o (mem_err)
    );

    sram_soc_checker u_checker (
        .clk_i, .rst_n, .depth_i (sram_words), .host_key_i (host_key),
        .wbs_cyc_i (wbs_cyc), .wbs_stb_i (wbs_stb), .wbs_we_i (wbs_we),
        .wbs_sel_i (wbs_sel), .wbs_adr_i (wbs_adr), .wbs_dat_i (wbs_dat),
        .wbs_ack_i (wbs_ack), .wbs_rdata_i (wbs_rdata),
        .core_req_i (core_req), .core_gnt_i (core_gnt), .core_addr_i (core_addr),
        .core_we_i (core_we), .core_be_i (core_be), .core_wdata_i (core_wdata),
        .core_rvalid_i (core_rvalid), .core_rdata_i (core_rdata),
        .mem_err_i (mem_err), .error_count_o (checker_errors)
    );

    bind sram_port_arbiter sram_soc_asserts u_arb_asserts (
        .clk_i, .rst_n,
        .host_req_i (host.req), .host_gnt_i (host.gnt), .host_rvalid_i (host.rvalid),
        .core_req_i (core.req), .core_gnt_i (core.gnt), .core_rvalid_i (core.rvalid)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic int total_errors();
        return tb_errors + checker_errors
            + u_sram_soc_top.u_sram_port_arbiter.u_arb_asserts.fail_count;
    endfunction

    function automatic addr_t random_offset();
        return addr_t'(($unsigned($random(seed)) % TEST_WORDS) * 4);
    endfunction

    // Depends on every address bit
    function automatic data_t fill_word(input addr_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6d2b_79f5;
    endfunction

    task automatic apply_reset();
        @(posedge clk_i);
        #1;
        rst_n = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic host_transfer(input addr_t addr, input logic we, input be_t sel,
                                 input data_t wdata, input bit expect_ack);
        int waited;
        bit acked;
        @(posedge clk_i);
        #1;
        wbs_cyc = 1'b1;
        wbs_stb = 1'b1;
        wbs_we  = we;
        wbs_sel = sel;
        wbs_adr = addr;
        wbs_dat = wdata;
        waited  = 0;
        acked   = 1'b0;
        while (!acked && waited < ACK_LIMIT) begin
            @(posedge clk_i);
            waited++;
            acked = wbs_ack;
        end
        #1;
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        // Strobe seen at the first edge, ack two cycles after it
        if (expect_ack && !acked) begin
            $display("Host cycle to %h got no ack within %0d cycles", addr, ACK_LIMIT);
            tb_errors++;
        end else if (expect_ack && waited != 3) begin
            $display("[ERROR] %0t ns: host ack after %0d edges, expected 3", $time, waited);
            tb_errors++;
        end else if (!expect_ack && acked) begin
            $display("Locked host cycle to %h was acknowledged", addr);
            tb_errors++;
        end
    endtask

    task automatic core_transfer(input addr_t addr, input logic we, input be_t be,
                                 input data_t wdata, output int gnt_wait);
        int waited;
        bit granted;
        @(posedge clk_i);
        #1;
        core_req   = 1'b1;
        core_addr  = addr;
        core_we    = we;
        core_be    = be;
        core_wdata = wdata;
        waited     = 0;
        granted    = 1'b0;
        while (!granted && waited < ACK_LIMIT) begin
            @(posedge clk_i);
            waited++;
            granted = core_gnt;
        end
        #1;
        core_req = 1'b0;
        gnt_wait = waited;
        if (!granted) begin
            $display("Core request to %h was never granted", addr);
            tb_errors++;
        end else begin
            @(posedge clk_i);
            if (core_rvalid !== 1'b1) begin
                $display("[ERROR] %0t ns: core rvalid missing one cycle after grant", $time);
                tb_errors++;
            end
        end
    endtask

    task automatic close_test(input int num, input string name);
        int errs;
        repeat (2) @(posedge clk_i);
        errs = total_errors() - errors_at_start;
        if (errs == 0) begin
            tests_passed++;
            $display("Test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: fail with %0d errors", num, name, errs);
        end
        errors_at_start = total_errors();
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        addr_t off;
        int    core_wait;
        seed       = 32'h8f81_763e;
        rst_n      = 1'b0;
        wbs_cyc    = 1'b0;
        wbs_stb    = 1'b0;
        wbs_we     = 1'b0;
        wbs_sel    = '0;
        wbs_adr    = '0;
        wbs_dat    = '0;
        host_key   = HOST_UNLOCK_KEY;
        core_req   = 1'b0;
        core_addr  = '0;
        core_we    = 1'b0;
        core_be    = '0;
        core_wdata = '0;
        sram_words = u_sram_soc_top.SRAM_WORDS;
        apply_reset();

        // Known contents for the words under test
        for (int i = 0; i < TEST_WORDS; i++) begin
            core_transfer(SRAM_BASE + 4 * i, 1'b1, 4'hF, fill_word(SRAM_BASE + 4 * i), core_wait);
        end
        errors_at_start = total_errors();

        for (int i = 0; i < 12; i++) begin
            off = random_offset();
            host_transfer(REMAP_LO + off, 1'b1, be_t'($random(seed)), $random(seed), 1'b1);
            host_transfer(REMAP_LO + off, 1'b0, 4'hF, '0, 1'b1);
            core_transfer(SRAM_BASE + off, 1'b0, 4'hF, '0, core_wait);
        end
        close_test(1, "host remap window");

        #1;
        host_key = 4'h5;
        off = random_offset();
        host_transfer(REMAP_LO + off, 1'b1, 4'hF, $random(seed), 1'b0);
        host_key = HOST_UNLOCK_KEY;
        core_transfer(SRAM_BASE + off, 1'b0, 4'hF, '0, core_wait);
        close_test(2, "locked host");

        for (int i = 0; i < 40; i++) begin
            core_transfer(SRAM_BASE + random_offset(), 1'($random(seed)),
                          be_t'($random(seed)), $random(seed), core_wait);
        end
        close_test(3, "core byte enables");

        for (int i = 0; i < 8; i++) begin
            off = random_offset();
            fork
                host_transfer(REMAP_LO + off, 1'($random(seed)), be_t'($random(seed)),
                              $random(seed), 1'b1);
                core_transfer(SRAM_BASE + (i[0] ? random_offset() : off), 1'($random(seed)),
                              be_t'($random(seed)), $random(seed), core_wait);
            join
            if (core_wait != 2) begin
                $display("[ERROR] %0t ns: core granted after %0d edges, expected 2",
                         $time, core_wait);
                tb_errors++;
            end
        end
        close_test(4, "contention");

        // Just past the end aliases word 0 in the index bits
        core_transfer(SRAM_BASE + 4 * sram_words, 1'b1, 4'hF, $random(seed), core_wait);
        core_transfer(SRAM_BASE, 1'b0, 4'hF, '0, core_wait);
        core_transfer(32'h1000_0000, 1'b0, 4'hF, '0, core_wait);
        core_transfer(SRAM_BASE + 4 * sram_words, 1'b0, 4'hF, '0, core_wait);
        if (mem_err !== 1'b1) begin
            $display("[ERROR] %0t ns: mem_err not set after illegal access", $time);
            tb_errors++;
        end
        apply_reset();
        @(posedge clk_i);
        if (mem_err !== 1'b0) begin
            $display("[ERROR] %0t ns: mem_err still set after reset", $time);
            tb_errors++;
        end
        close_test(5, "illegal access");

        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/obi_if.sv
`timescale 1ns/1ps
`default_nettype none

interface obi_if;
    import soc_bus_pkg::*;

    // Request channel, held by the manager until gnt
    logic  req;
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;

    // Grant and single-pulse response
    logic  gnt;
    logic  rvalid;
    data_t rdata;

    modport manager (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    modport subordinate (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

//--- hw/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

    ////////////////////////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////////////////////////

    // Byte address on every OBI and Wishbone path
    typedef logic [31:0] addr_t;

    typedef logic [31:0] data_t;

    // One enable per byte lane
    typedef logic [3:0]  be_t;

    // Field from the logic analyzer that opens the host path
    typedef logic [3:0]  host_key_t;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    localparam addr_t SRAM_BASE = 32'h8000_0000;

    // Host window, low bound inclusive and high bound exclusive
    localparam addr_t REMAP_LO  = 32'h3000_0000;
    localparam addr_t REMAP_HI  = 32'h8000_0000;

    // Host requests pass only while the key holds this value
    localparam host_key_t HOST_UNLOCK_KEY = 4'hA;

endpackage

`default_nettype wire

//--- hw/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
    parameter int unsigned SRAM_WORDS = 256
) (
    input  logic       clk_i,
    input  logic       rst_n,
    obi_if.subordinate bus,
    output logic       illegal_o
);
    import soc_bus_pkg::*;

    localparam int unsigned IDX_W      = $clog2(SRAM_WORDS);
    localparam addr_t       SRAM_LIMIT = SRAM_BASE + addr_t'(4 * SRAM_WORDS);

    data_t            mem_q [SRAM_WORDS];
    addr_t            offset;
    logic [IDX_W-1:0] word_idx;
    logic             in_range;
    logic             accept;
    logic             rvalid_q;
    data_t            rdata_q;

    // Single-cycle bank, never back-pressures
    assign bus.gnt = bus.req;
    assign accept  = bus.req && bus.gnt;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    assign in_range = (bus.addr >= SRAM_BASE) && (bus.addr < SRAM_LIMIT);
    assign offset   = bus.addr - SRAM_BASE;
    assign word_idx = offset[IDX_W+1:2];

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    // Only enabled lanes change, out-of-range writes fall away
    always_ff @(posedge clk_i) begin
        if (accept && bus.we && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.be[b]) begin
                    mem_q[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Illegal reads return zero
    always_ff @(posedge clk_i) begin
        if (accept && !bus.we) begin
            rdata_q <= in_range ? mem_q[word_idx] : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            rvalid_q  <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            rvalid_q <= accept;
            // Sticky until reset, rises with the offending rvalid
            if (accept && !in_range) begin
                illegal_o <= 1'b1;
            end
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule

`default_nettype wire

//--- hw/sram_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sram_port_arbiter (
    input  logic       clk_i,
    input  logic       rst_n,

    // Requesters, host has priority
    obi_if.subordinate host,
    obi_if.subordinate core,

    // Shared path to the bank
    obi_if.manager     mem
);

    logic host_sel;
    logic accept;
    logic host_owner_q;

    ////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////

    // Host takes the bank whenever it asks
    assign host_sel = host.req;

    assign mem.req   = host.req || core.req;
    assign mem.addr  = host_sel ? host.addr  : core.addr;
    assign mem.we    = host_sel ? host.we    : core.we;
    assign mem.be    = host_sel ? host.be    : core.be;
    assign mem.wdata = host_sel ? host.wdata : core.wdata;

    // Core waits out any host request
    assign host.gnt = host.req && mem.gnt;
    assign core.gnt = core.req && !host.req && mem.gnt;

    assign accept = mem.req && mem.gnt;

    ////////////////////////////////////////////////////////////
    // Response steering
    ////////////////////////////////////////////////////////////

    // Owner of the access now in the bank, one cycle deep
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            host_owner_q <= 1'b0;
        end else if (accept) begin
            host_owner_q <= host_sel;
        end
    end

    // Exactly one side sees each rvalid
    assign host.rvalid = mem.rvalid && host_owner_q;
    assign core.rvalid = mem.rvalid && !host_owner_q;

    // Data goes to both, only the owner's rvalid qualifies it
    assign host.rdata = mem.rdata;
    assign core.rdata = mem.rdata;

endmodule

`default_nettype wire

//--- hw/sram_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_soc_top #(
    parameter int unsigned SRAM_WORDS = 256
) (
    input  logic                   clk_i,
    input  logic                   rst_n,

    // Host Wishbone slave
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_we_i,
    input  soc_bus_pkg::be_t       wbs_sel_i,
    input  soc_bus_pkg::addr_t     wbs_adr_i,
    input  soc_bus_pkg::data_t     wbs_dat_i,
    output logic                   wbs_ack_o,
    output soc_bus_pkg::data_t     wbs_dat_o,

    // Unlock field from the logic analyzer
    input  soc_bus_pkg::host_key_t host_key_i,

    // Core data port
    input  logic                   core_req_i,
    output logic                   core_gnt_o,
    input  soc_bus_pkg::addr_t     core_addr_i,
    input  logic                   core_we_i,
    input  soc_bus_pkg::be_t       core_be_i,
    input  soc_bus_pkg::data_t     core_wdata_i,
    output logic                   core_rvalid_o,
    output soc_bus_pkg::data_t     core_rdata_o,

    output logic                   mem_err_o
);

    obi_if host_bus ();
    obi_if core_bus ();
    obi_if sram_bus ();

    ////////////////////////////////////////////////////////////
    // Core port onto its bus
    ////////////////////////////////////////////////////////////

    assign core_bus.req   = core_req_i;
    assign core_bus.addr  = core_addr_i;
    assign core_bus.we    = core_we_i;
    assign core_bus.be    = core_be_i;
    assign core_bus.wdata = core_wdata_i;
    assign core_gnt_o     = core_bus.gnt;
    assign core_rvalid_o  = core_bus.rvalid;
    assign core_rdata_o   = core_bus.rdata;

    wb_obi_bridge u_wb_obi_bridge (
        .clk_i,
        .rst_n,
        .host_key_i,
        .wbs_cyc_i,
        .wbs_stb_i,
        .wbs_we_i,
        .wbs_sel_i,
        .wbs_adr_i,
        .wbs_dat_i,
        .wbs_ack_o,
        .wbs_dat_o,
        .obi        (host_bus.manager)
    );

    sram_port_arbiter u_sram_port_arbiter (
        .clk_i,
        .rst_n,
        .host  (host_bus.subordinate),
        .core  (core_bus.subordinate),
        .mem   (sram_bus.manager)
    );

    sram_bank #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_sram_bank (
        .clk_i,
        .rst_n,
        .bus       (sram_bus.subordinate),
        .illegal_o (mem_err_o)
    );

endmodule

`default_nettype wire

//--- hw/wb_obi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_obi_bridge (
    input  logic                   clk_i,
    input  logic                   rst_n,
    input  soc_bus_pkg::host_key_t host_key_i,

    // Wishbone classic slave
    input  logic                   wbs_cyc_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_we_i,
    input  soc_bus_pkg::be_t       wbs_sel_i,
    input  soc_bus_pkg::addr_t     wbs_adr_i,
    input  soc_bus_pkg::data_t     wbs_dat_i,
    output logic                   wbs_ack_o,
    output soc_bus_pkg::data_t     wbs_dat_o,

    // Toward the arbiter
    obi_if.manager                 obi
);
    import soc_bus_pkg::*;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_WAIT_RSP,
        BR_ACK
    } br_state_e;

    br_state_e state_q;
    br_state_e state_d;
    logic      unlocked;
    logic      wb_strobe;
    addr_t     host_addr;

    assign unlocked  = (host_key_i == HOST_UNLOCK_KEY);
    assign wb_strobe = wbs_cyc_i && wbs_stb_i;

    ////////////////////////////////////////////////////////////
    // Address remap and request fields
    ////////////////////////////////////////////////////////////

    // Host window lands on the SRAM base by swapping the top nibble
    always_comb begin
        host_addr = wbs_adr_i;
        if (wbs_adr_i >= REMAP_LO && wbs_adr_i < REMAP_HI) begin
            host_addr = {SRAM_BASE[31:28], wbs_adr_i[27:0]};
        end
    end

    assign obi.addr  = host_addr;
    assign obi.we    = wbs_we_i;
    assign obi.be    = wbs_sel_i;
    assign obi.wdata = wbs_dat_i;

    ////////////////////////////////////////////////////////////
    // Transfer FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        obi.req = 1'b0;
        case (state_q)
            BR_IDLE: begin
                // Locked key keeps the request low, so no ack ever follows
                if (wb_strobe && unlocked) begin
                    obi.req = 1'b1;
                    if (obi.gnt) begin
                        state_d = BR_WAIT_RSP;
                    end
                end
            end
            BR_WAIT_RSP: begin
                if (obi.rvalid) begin
                    state_d = BR_ACK;
                end
            end
            // Strobe is still high here, so no new request this cycle
            BR_ACK:  state_d = BR_IDLE;
            default: state_d = BR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            state_q <= BR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Response word held through the ack cycle
    always_ff @(posedge clk_i) begin
        if (state_q == BR_WAIT_RSP && obi.rvalid) begin
            wbs_dat_o <= obi.rdata;
        end
    end

    assign wbs_ack_o = (state_q == BR_ACK);

endmodule

`default_nettype wire

//--- list.f
hw/soc_bus_pkg.sv
hw/obi_if.sv
hw/wb_obi_bridge.sv
hw/sram_port_arbiter.sv
hw/sram_bank.sv
hw/sram_soc_top.sv
dv/sram_soc_asserts.sv
dv/sram_soc_checker.sv
dv/tb_sram_soc.sv
